// File: tb.f
hdl/eg_pkg.sv
hdl/slot_delay.sv
hdl/eg_counter.sv
hdl/eg_rate.sv
hdl/eg_core.sv
hdl/eg_mix.sv
hdl/eg_top.sv
test/tb_eg.sv

// File: run.sh
#!/bin/sh
# build and run the envelope generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_eg -f tb.f -o tb_eg_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_eg_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Regression passed" && exit 0 || exit 1

// File: test/tb_eg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// envelope generator testbench
//   LFSR, per-slot stimulus table, frame driver
//   reference queue, compare tasks and timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_eg;
    import eg_pkg::*;

    localparam int NFRAMES  = 120;
    localparam int NCYC     = NFRAMES * SLOTS;
    localparam int LIMIT    = NCYC + 16 + 200;   // reset plus frames plus margin
    localparam int SETTLE   = 36;    // frames after key-on until decay holds
    localparam int REL_SPAN = 104;   // frames after key-off to reach silence
    localparam int NEVER    = 100000;
    localparam int K_IDLE   = 0;
    localparam int K_INST   = 1;
    localparam int K_SETTLE = 2;
    localparam int K_REL    = 3;
    localparam int K_PULSE  = 4;

    logic              clk;
    logic              rst;
    logic              cen;
    logic              zero;
    eg_cfg_t           cfg;
    logic              keyon;
    logic [6:0]        am;
    logic              pg_rst;
    eg_level_t         eg_out;

    eg_cfg_t    row_cfg  [SLOTS];
    int         row_kind [SLOTS];
    int         on_f     [SLOTS];
    int         off_f    [SLOTS];
    int         on2_f    [SLOTS];
    eg_level_t  prev_out [SLOTS];
    logic [6:0] am_hist  [NCYC];
    logic [31:0] lfsr_state = 32'ha30c;
    int         ref_q[$];
    int         cycles = 0;

    eg_top #(.slots(SLOTS)) dut_i (
        .clk(clk), .rst(rst), .cen(cen), .zero(zero), .cfg(cfg),
        .keyon(keyon), .am(am), .pg_rst(pg_rst), .eg_out(eg_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout, the run did not finish in %0d cycles", LIMIT);
            $display("Regression failed");
            $fatal(1);
        end
    end

    // fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s (t=%0t)", msg, $time);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_level(input eg_level_t got, input eg_level_t exp,
                               input int s, input int f);
        if (got !== exp) begin
            $display("ERR t=%0t eg_out slot %0d frame %0d got %0d exp %0d",
                     $time, s, f, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_pulse(input logic got, input logic exp, input int s, input int f);
        if (got !== exp) begin
            $display("ERR t=%0t pg_rst slot %0d frame %0d got %0b exp %0b",
                     $time, s, f, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic logic key_at(input int s, input int f);
        if (f < 0) return 1'b0;
        return (f >= on_f[s] && f < off_f[s]) || (f >= on2_f[s]);
    endfunction

    // min(1023, 8 tl + level + 2 amf)
    function automatic eg_level_t mix_expect(input eg_cfg_t c, input int lvl,
                                             input logic [6:0] a);
        int amf;
        int v;
        amf = (!c.amsen || c.ams == 2'd0) ? 0 : (int'(a) << (c.ams - 1));
        v = 8 * int'(c.tl) + lvl + 2 * amf;
        return (v > 1023) ? 10'd1023 : eg_level_t'(v);
    endfunction

    task automatic set_row(input int s, input int kind, input eg_cfg_t c,
                           input int on, input int off, input int on2);
        row_cfg[s]  = c;
        row_kind[s] = kind;
        on_f[s]     = on;
        off_f[s]    = off;
        on2_f[s]    = on2;
    endtask

    task automatic build_table();
        eg_cfg_t c;
        logic [31:0] r;
        for (int s = 0; s < SLOTS; s++) begin
            c = '0;
            r = rand_bits(7);
            c.tl = r[6:0];
            set_row(s, K_IDLE, c, NEVER, NEVER, NEVER);
        end
        for (int s = 1; s <= 4; s++) begin
            c = '0;
            c.arate = 5'd31;          // instant attack with decay rates at 0
            r = rand_bits(7);
            c.tl = r[6:0];
            r = rand_bits(3);
            c.ams   = r[1:0];
            c.amsen = r[2];
            set_row(s, K_INST, c, s, NEVER, NEVER);
        end
        c = '0;
        c.arate = 5'd31;
        c.rate1 = 5'd31;
        c.d1l   = 4'd1;
        set_row(5, K_SETTLE, c, 1, NEVER, NEVER);
        c.d1l   = 4'd2;
        set_row(6, K_SETTLE, c, 2, NEVER, NEVER);
        c = '0;
        c.arate = 5'd31;
        c.rrate = 4'd15;
        c.tl    = 7'd96;              // 768 floor shortens the release climb
        set_row(7, K_REL, c, 1, 5, NEVER);
        c = '0;
        c.arate = 5'd31;
        set_row(8, K_PULSE, c, 1, 3, 6);  // retrigger after key-off
    endtask

    task automatic check_output(input int k);
        int s;
        int f;
        int lo;
        eg_cfg_t c;
        eg_level_t out;
        s   = k % SLOTS;
        f   = k / SLOTS;
        c   = row_cfg[s];
        out = eg_out;
        if (row_kind[s] == K_IDLE || f < on_f[s]) begin
            check_level(out, 10'd1023, s, f);
        end else if (row_kind[s] == K_INST && f > on_f[s]) begin
            check_level(out, mix_expect(c, 0, am_hist[k + 4]), s, f);
        end else if (row_kind[s] == K_SETTLE && f >= on_f[s] + SETTLE) begin
            lo = (c.d1l == 4'hf) ? 16 * 32 : int'(c.d1l) * 32;
            if (int'(out) < lo || int'(out) > lo + 8) begin
                fail_run($sformatf("decay level %0d of slot %0d outside %0d..%0d",
                                   out, s, lo, lo + 8));
            end
            if (f > on_f[s] + SETTLE) check_level(out, prev_out[s], s, f);
        end else if (row_kind[s] == K_REL && f > on_f[s] && f < off_f[s]) begin
            check_level(out, mix_expect(c, 0, 7'd0), s, f);
        end else if (row_kind[s] == K_REL && f >= off_f[s]) begin
            if (out < prev_out[s]) begin
                fail_run($sformatf("release output of slot %0d fell from %0d to %0d",
                                   s, prev_out[s], out));
            end
            if (f >= off_f[s] + REL_SPAN) check_level(out, 10'd1023, s, f);
        end
        prev_out[s] = out;
    endtask

    initial begin
        int s;
        int f;
        logic [31:0] r;
        rst   = 1'b1;
        cen   = 1'b1;
        zero  = 1'b0;
        cfg   = '0;
        keyon = 1'b0;
        am    = 7'd0;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int d = 0; d < NCYC; d++) begin
            @(posedge clk);
            s = d % SLOTS;
            f = d / SLOTS;
            r = rand_bits(7);
            am_hist[d] = r[6:0];
            zero  <= (s == 0);
            cfg   <= row_cfg[s];
            keyon <= key_at(s, f);
            am    <= r[6:0];
            ref_q.push_back(d);
            @(negedge clk);
            if (d > 0) begin
                // pg_rst belongs to the slot driven one cycle earlier
                s = (d - 1) % SLOTS;
                f = (d - 1) / SLOTS;
                check_pulse(pg_rst, key_at(s, f) && !key_at(s, f - 1), s, f);
            end
            if (ref_q.size() > EG_LATENCY) check_output(ref_q.pop_front());
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/eg_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// envelope generator top level
//   counter, rate, core and mix instances
//   delay lines for the late config fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module eg_top #(
    parameter int slots = eg_pkg::SLOTS
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              zero,
    input  eg_pkg::eg_cfg_t   cfg,
    input  logic              keyon,
    input  logic [6:0]        am,
    output logic              pg_rst,
    output eg_pkg::eg_level_t eg_out
);
    import eg_pkg::*;

    logic [14:0] count;
    eg_state_t   phase;
    logic [4:0]  cfg_sel;
    logic        step;
    logic        sum_up;
    eg_level_t   level;
    logic [6:0]  kc_ks;      // keycode and ks, one slot late
    logic [9:0]  mix_bits;   // tl, ams, amsen at level stage

    eg_counter u_counter (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .zero  (zero),
        .count (count)
    );

    slot_delay #(.width(7), .stages(1)) u_kc_dly (
        .clk(clk), .rst(rst), .cen(cen), .din({cfg.keycode, cfg.ks}), .dout(kc_ks)
    );

    eg_rate #(.slots(slots)) u_rate (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .count   (count),
        .phase   (phase),
        .cfg_sel (cfg_sel),
        .keycode (kc_ks[6:2]),
        .ks      (kc_ks[1:0]),
        .step    (step),
        .sum_up  (sum_up)
    );

    eg_core #(.slots(slots)) u_core (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .cfg     (cfg),
        .keyon   (keyon),
        .step    (step),
        .sum_up  (sum_up),
        .phase   (phase),
        .cfg_sel (cfg_sel),
        .pg_rst  (pg_rst),
        .level   (level)
    );

    slot_delay #(.width(10), .stages(EG_LVL_STAGE)) u_mix_dly (
        .clk(clk), .rst(rst), .cen(cen), .din({cfg.tl, cfg.ams, cfg.amsen}), .dout(mix_bits)
    );

    eg_mix u_mix (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .level  (level),
        .tl     (mix_bits[9:3]),
        .ams    (mix_bits[2:1]),
        .amsen  (mix_bits[0]),
        .am     (am),
        .eg_out (eg_out)
    );

endmodule

`default_nettype wire

// File: hdl/eg_mix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// envelope output mix
//   AM depth scaling, total level sum
//   saturation at 1023 and output padding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module eg_mix (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  eg_pkg::eg_level_t level,
    input  logic [6:0]        tl,
    input  logic [1:0]        ams,
    input  logic              amsen,
    input  logic [6:0]        am,
    output eg_pkg::eg_level_t eg_out
);
    import eg_pkg::*;

    logic [8:0]  am_final;
    logic [11:0] sum;
    eg_level_t   sat;

    always_comb begin
        if (!amsen || ams == 2'd0) begin
            am_final = 9'd0;
        end else begin
            am_final = {2'b00, am} << (ams - 2'd1);  // x1, x2, x4
        end
        // tl weighs 8 level steps, am 2 steps
        sum = {2'b00, tl, 3'b000} + {2'b00, level} + {2'b00, am_final, 1'b0};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sat <= 10'h3ff;
        end else if (cen) begin
            sat <= (sum[11:10] != 2'b00) ? 10'h3ff : sum[9:0];
        end
    end

    slot_delay #(
        .width   (10),
        .stages  (EG_LATENCY - EG_LVL_STAGE - 1),
        .rst_val (10'h3ff)
    ) u_pad (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .din  (sat),
        .dout (eg_out)
    );

endmodule

`default_nettype wire

// File: hdl/eg_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// envelope core
//   key edge detect and phase FSM per slot
//   attack and decay level update, saturating
//   state and level recirculate once per frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module eg_core #(
    parameter int slots = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  eg_pkg::eg_cfg_t   cfg,
    input  logic              keyon,
    input  logic              step,
    input  logic              sum_up,
    output eg_pkg::eg_state_t phase,
    output logic [4:0]        cfg_sel,
    output logic              pg_rst,
    output eg_pkg::eg_level_t level
);
    import eg_pkg::*;

    localparam int UPD = EG_LVL_STAGE - 1;  // step and sum_up arrive here

    logic      key_last;
    logic      key_on;
    logic      key_off;
    logic      ar_off_0;
    logic      ar_off_3;
    logic [4:0] d1level;
    logic [1:0] state_0;
    logic [1:0] phase_3;
    eg_level_t level_0;
    eg_level_t level_3;
    eg_level_t level_next;
    eg_state_t next_phase;
    logic [4:0] next_sel;
    logic [5:0] rate_1;
    logic [5:0] rate_3;
    logic [8:0] ar_base;
    logic [9:0] ar_dec;
    logic [9:0] ar_result;

    assign key_on   = keyon && !key_last;
    assign key_off  = key_last && !keyon;
    assign ar_off_0 = key_on && (cfg.arate == 5'h1f);      // instant attack
    assign d1level  = (cfg.d1l == 4'hf) ? 5'h10 : {1'b0, cfg.d1l};

    always_comb begin
        next_phase = eg_state_t'(state_0);
        next_sel   = {cfg.rrate, 1'b1};
        if (key_off) begin
            next_phase = EG_RELEASE;
        end else if (key_on) begin
            next_phase = EG_ATTACK;
            next_sel   = cfg.arate;
        end else begin
            case (state_0)
                EG_ATTACK: begin
                    next_phase = (level_0 == 10'd0) ? EG_DECAY1 : EG_ATTACK;
                    next_sel   = (level_0 == 10'd0) ? cfg.rate1 : cfg.arate;
                end
                EG_DECAY1: begin
                    next_phase = (level_0[9:5] >= d1level) ? EG_DECAY2 : EG_DECAY1;
                    next_sel   = (level_0[9:5] >= d1level) ? cfg.rate2 : cfg.rate1;
                end
                EG_DECAY2: next_sel = cfg.rate2;
                default:   next_sel = {cfg.rrate, 1'b1};  // release, doubled plus one
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= EG_RELEASE;
            cfg_sel <= 5'd0;
            pg_rst  <= 1'b0;
        end else if (cen) begin
            phase   <= next_phase;
            cfg_sel <= next_sel;
            pg_rst  <= key_on;
        end
    end

    // local copy of the effective rate for the step size
    always_ff @(posedge clk) begin
        if (cen) begin
            rate_1 <= eg_rate_calc(next_sel, cfg.keycode, cfg.ks);
        end
    end

    always_comb begin
        case (rate_3[5:2])
            4'b1101:          ar_base = {2'd0, level_3[9:3]} + 9'd1;
            4'b1110, 4'b1111: ar_base = {1'b0, level_3[9:2]} + 9'd1;
            default:          ar_base = {3'd0, level_3[9:4]} + 9'd1;
        endcase
        if (rate_3[5:4] == 2'b11) begin
            ar_dec = step ? {ar_base, 1'b0} : {1'b0, ar_base};
        end else begin
            ar_dec = step ? {1'b0, ar_base} : 10'd0;
        end
        ar_result = (ar_dec < level_3) ? level_3 - ar_dec : 10'd0;

        if (ar_off_3) begin
            level_next = 10'd0;
        end else if (!sum_up) begin
            level_next = level_3;
        end else if (phase_3 == EG_ATTACK) begin
            level_next = (rate_3[5:1] == 5'h1f) ? 10'd0 : ar_result;
        end else if (level_3 > 10'd1015) begin
            level_next = 10'h3ff;   // clamp at silence
        end else begin
            case (rate_3[5:2])
                4'd12:   level_next = level_3 + {8'd0, step, ~step};
                4'd13:   level_next = level_3 + {7'd0, step, ~step, 1'b0};
                4'd14:   level_next = level_3 + {6'd0, step, ~step, 2'b0};
                4'd15:   level_next = level_3 + 10'd8;
                default: level_next = level_3 + {8'd0, step, 1'b0};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level <= 10'h3ff;
        end else if (cen) begin
            level <= level_next;
        end
    end

    slot_delay #(.width(1), .stages(slots), .rst_val(1'b0)) u_key_hist (
        .clk(clk), .rst(rst), .cen(cen), .din(keyon), .dout(key_last)
    );
    slot_delay #(.width(2), .stages(UPD - 1), .rst_val(EG_RELEASE)) u_state_a (
        .clk(clk), .rst(rst), .cen(cen), .din(phase), .dout(phase_3)
    );
    slot_delay #(.width(2), .stages(slots - UPD), .rst_val(EG_RELEASE)) u_state_b (
        .clk(clk), .rst(rst), .cen(cen), .din(phase_3), .dout(state_0)
    );
    slot_delay #(.width(10), .stages(slots - EG_LVL_STAGE), .rst_val(10'h3ff)) u_level_a (
        .clk(clk), .rst(rst), .cen(cen), .din(level), .dout(level_0)
    );
    slot_delay #(.width(10), .stages(UPD), .rst_val(10'h3ff)) u_level_b (
        .clk(clk), .rst(rst), .cen(cen), .din(level_0), .dout(level_3)
    );
    slot_delay #(.width(6), .stages(UPD - 1), .rst_val(6'd0)) u_rate (
        .clk(clk), .rst(rst), .cen(cen), .din(rate_1), .dout(rate_3)
    );
    slot_delay #(.width(1), .stages(UPD), .rst_val(1'b0)) u_ar_off (
        .clk(clk), .rst(rst), .cen(cen), .din(ar_off_0), .dout(ar_off_3)
    );

    // phase generator reset only follows a key being held down
    pg_rst_needs_key: assert property (
        @(posedge clk) disable iff (rst) cen |=> (!pg_rst || $past(keyon))
    ) else $error("pg_rst pulse without key-on");

endmodule

`default_nettype wire

// File: hdl/eg_rate.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// envelope rate stage
//   effective rate from code, keycode and scaling
//   counter tap choice and eight-step pattern
//   per-slot toggle detect for sum_up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module eg_rate #(
    parameter int slots = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [14:0]       count,
    input  eg_pkg::eg_state_t phase,
    input  logic [4:0]        cfg_sel,
    input  logic [4:0]        keycode,
    input  logic [1:0]        ks,
    output logic              step,
    output logic              sum_up
);
    import eg_pkg::*;

    logic [5:0]  rate_1;     // same cycle as cfg_sel
    logic [3:0]  tap_lo;
    logic [14:0] count_sh;
    logic [5:0]  rate_2;
    logic [2:0]  cnt_2;
    logic        attack_2;
    logic [7:0]  pattern;
    logic        step_2;
    logic        prev_bit;   // this slot's tap bit one frame ago

    assign rate_1 = eg_rate_calc(cfg_sel, keycode, ks);

    // faster rates read lower counter bits, attack one bit lower still
    always_comb begin
        if (phase == EG_ATTACK) begin
            tap_lo = (rate_1[5:2] > 4'd11) ? 4'd0 : 4'd11 - rate_1[5:2];
        end else begin
            tap_lo = (rate_1[5:2] > 4'd12) ? 4'd0 : 4'd12 - rate_1[5:2];
        end
        count_sh = count >> tap_lo;
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            rate_2   <= rate_1;
            cnt_2    <= count_sh[2:0];
            attack_2 <= (phase == EG_ATTACK);
        end
    end

    always_comb begin
        if (rate_2[5:4] == 2'b11) begin
            if (rate_2[5:2] == 4'hf && attack_2) begin
                pattern = 8'b1111_1111;  // fastest attack
            end else begin
                case (rate_2[1:0])
                    2'd0:    pattern = 8'b0000_0000;
                    2'd1:    pattern = 8'b1000_1000;
                    2'd2:    pattern = 8'b1010_1010;
                    default: pattern = 8'b1110_1110;
                endcase
            end
        end else begin
            if (rate_2[5:2] == 4'd0 && !attack_2) begin
                pattern = 8'b1111_1110;  // slowest decay floor
            end else begin
                case (rate_2[1:0])
                    2'd0:    pattern = 8'b1010_1010;
                    2'd1:    pattern = 8'b1110_1010;
                    2'd2:    pattern = 8'b1110_1110;
                    default: pattern = 8'b1111_1110;
                endcase
            end
        end
        step_2 = (rate_2[5:1] == 5'd0) ? 1'b0 : pattern[cnt_2];  // rate 0 holds
    end

    slot_delay #(
        .width   (1),
        .stages  (slots),
        .rst_val (1'b0)
    ) u_prev_bit (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .din  (cnt_2[0]),
        .dout (prev_bit)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            step   <= 1'b0;
            sum_up <= 1'b0;
        end else if (cen) begin
            step   <= step_2;
            sum_up <= cnt_2[0] != prev_bit;
        end
    end

endmodule

`default_nettype wire

// File: hdl/eg_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// global envelope counter
//   steps once every three frames, paced by zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module eg_counter (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        zero,
    output logic [14:0] count
);

    logic [1:0] base;  // frames since the last step

    // one frame is 32 enabled clocks, zero marks its start
    always_ff @(posedge clk) begin
        if (rst) begin
            base  <= 2'd0;
            count <= 15'd0;
        end else if (cen && zero) begin
            if (base == 2'd2) begin
                base  <= 2'd0;
                count <= count + 15'd1;  // wraps freely
            end else begin
                base <= base + 2'd1;
            end
        end
    end

    // divide-by-three must never reach its unused code
    base_in_range: assert property (
        @(posedge clk) disable iff (rst) base <= 2'd2
    ) else $error("envelope base counter left its 0..2 range");

endmodule

`default_nettype wire

// File: hdl/slot_delay.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cen-gated shift register with a reset value
//   carries per-slot values around the frame
//   and lines up late fields with the pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module slot_delay #(
    parameter int               width   = 1,
    parameter int               stages  = 1,   // at least one
    parameter logic [width-1:0] rst_val = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout
);

    logic [width-1:0] sr [stages];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < stages; i++) begin
                sr[i] <= rst_val;
            end
        end else if (cen) begin
            sr[0] <= din;
            // one slot per enabled clock
            for (int i = 1; i < stages; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    assign dout = sr[stages-1];

endmodule

`default_nettype wire

// File: hdl/eg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// envelope generator shared definitions
//   phase encoding and attenuation level type
//   per-slot configuration word
//   pipeline depth constants, effective rate function
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package eg_pkg;

    localparam int SLOTS        = 32;  // operator slots per frame
    localparam int EG_LVL_STAGE = 4;   // level leaves the core here
    localparam int EG_LATENCY   = 9;   // cfg in to eg_out

    typedef enum logic [1:0] {
        EG_ATTACK  = 2'd0,
        EG_DECAY1  = 2'd1,
        EG_DECAY2  = 2'd2,
        EG_RELEASE = 2'd3
    } eg_state_t;

    // 0 is loudest, 1023 silent, about 0.094 dB per step
    typedef logic [9:0] eg_level_t;

    typedef struct packed {
        logic [4:0] arate;
        logic [4:0] rate1;
        logic [4:0] rate2;
        logic [3:0] rrate;
        logic [3:0] d1l;      // decay 1 target, top five level bits
        logic [1:0] ks;       // key scaling depth
        logic [4:0] keycode;
        logic [6:0] tl;
        logic [1:0] ams;
        logic       amsen;
    } eg_cfg_t;

    // twice the rate code plus the scaled keycode, clamped to 63
    function automatic logic [5:0] eg_rate_calc(input logic [4:0] code,
                                                input logic [4:0] kc,
                                                input logic [1:0] ks);
        logic [6:0] sum;
        if (code == 5'd0) begin
            sum = 7'd0;  // code 0 stays frozen whatever the key
        end else begin
            sum = {1'b0, code, 1'b0} + {2'b00, kc >> (2'd3 - ks)};
        end
        return sum[6] ? 6'd63 : sum[5:0];
    endfunction

endpackage

`default_nettype wire
